// File: src/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

    localparam int xlen = 32;
    localparam int bus_width = 32;
    localparam int bus_bytes = bus_width / 8;

    localparam int mem_words = 1024;
    localparam int word_aw = $clog2(mem_words);

    // address map with a 4 KiB window per target
    localparam logic [xlen-1:0] rom_base = 32'h0000_0000;
    localparam logic [xlen-1:0] tcm_base = 32'h1000_0000;
    localparam logic [xlen-1:0] sel_mask = 32'hffff_f000;

    localparam string rom_init_file = "rom_init.hex";

    typedef enum logic [1:0] {
        acc_byte,
        acc_half,
        acc_word
    } bus_acc_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_ibus,
        arb_dbus
    } arb_state_t;

    typedef enum logic [7:0] {
        fault_none,
        fault_ibus,
        fault_dbus
    } fault_cause_t;

    // w_rb high for a write
    typedef struct packed {
        logic [xlen-1:0]      addr;
        logic                 w_rb;
        bus_acc_t             acc;
        logic [bus_width-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic tcm;
    } target_sel_t;

    typedef struct packed {
        logic decode;
        logic rom;
        logic tcm;
    } fault_src_t;

endpackage

`default_nettype wire

// File: src/addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              req,
    input  fabric_pkg::bus_req_t              pkt,
    input  logic                              fault,
    output fabric_pkg::target_sel_t           sel_req,
    input  logic                              rom_resp,
    input  logic                              tcm_resp,
    input  logic [fabric_pkg::bus_width-1:0]  rom_rdata,
    input  logic [fabric_pkg::bus_width-1:0]  tcm_rdata,
    output logic                              resp,
    output logic [fabric_pkg::bus_width-1:0]  rdata,
    output logic                              decode_fault
);
    import fabric_pkg::*;

    target_sel_t sel;
    target_sel_t resp_sel;
    logic        hit;

    // window compare on the top address bits
    always_comb begin
        sel.rom = (pkt.addr & sel_mask) == rom_base;
        sel.tcm = (pkt.addr & sel_mask) == tcm_base;
    end

    assign hit = sel.rom | sel.tcm;

    always_comb begin
        sel_req.rom = req & sel.rom;
        sel_req.tcm = req & sel.tcm;
    end

    // remember which target owns the outstanding access
    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp_sel <= '0;
        end else if (req) begin
            resp_sel <= sel;
        end
    end

    // responses are blocked once a fault is recorded
    assign resp = ~fault & ((rom_resp & resp_sel.rom) | (tcm_resp & resp_sel.tcm));

    assign rdata = resp_sel.tcm ? tcm_rdata : rom_rdata;

    assign decode_fault = req & ~hit;

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              ibus_req,
    input  logic                              dbus_req,
    input  fabric_pkg::bus_req_t              ibus_pkt,
    input  fabric_pkg::bus_req_t              dbus_pkt,
    output logic                              ibus_resp,
    output logic                              dbus_resp,
    output logic [fabric_pkg::bus_width-1:0]  ibus_rdata,
    output logic [fabric_pkg::bus_width-1:0]  dbus_rdata,
    output logic                              ibus_fault,
    output logic                              dbus_fault,
    output logic                              tgt_req,
    output fabric_pkg::bus_req_t              tgt_pkt,
    input  logic                              tgt_resp,
    input  logic [fabric_pkg::bus_width-1:0]  tgt_rdata,
    input  logic                              tgt_fault
);
    import fabric_pkg::*;

    bus_req_t   ibus_lat;
    bus_req_t   dbus_lat;
    bus_req_t   ibus_cur;
    bus_req_t   dbus_cur;
    logic       ibus_pend;
    logic       dbus_pend;
    arb_state_t state;
    arb_state_t next_state;

    always_ff @(posedge clk) begin
        if (ibus_req) begin
            ibus_lat <= ibus_pkt;
        end
        if (dbus_req) begin
            dbus_lat <= dbus_pkt;
        end
    end

    // bypass so an idle arbiter issues in the request cycle
    always_comb begin
        ibus_cur = ibus_req ? ibus_pkt : ibus_lat;
        ibus_cur.w_rb = 1'b0;
        dbus_cur = dbus_req ? dbus_pkt : dbus_lat;
    end

    // access outstanding per bus from req until its resp
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ibus_pend <= 1'b0;
            dbus_pend <= 1'b0;
        end else begin
            if (ibus_req || ibus_resp) begin
                ibus_pend <= ibus_req;
            end
            if (dbus_req || dbus_resp) begin
                dbus_pend <= dbus_req;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= arb_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            arb_ibus: begin
                if (!tgt_resp) begin
                    next_state = arb_ibus;
                end else if (dbus_req || dbus_pend) begin
                    next_state = arb_dbus;
                end else if (ibus_req) begin
                    next_state = arb_ibus;
                end else begin
                    next_state = arb_idle;
                end
            end
            arb_dbus: begin
                if (!tgt_resp) begin
                    next_state = arb_dbus;
                end else if (ibus_req || ibus_pend) begin
                    next_state = arb_ibus;
                end else if (dbus_req) begin
                    next_state = arb_dbus;
                end else begin
                    next_state = arb_idle;
                end
            end
            default: begin
                // data bus wins a tie
                if (dbus_req) begin
                    next_state = arb_dbus;
                end else if (ibus_req) begin
                    next_state = arb_ibus;
                end else begin
                    next_state = arb_idle;
                end
            end
        endcase
    end

    // new access goes out from idle or back-to-back with the resp
    assign tgt_req = ((state == arb_idle) || tgt_resp) && (next_state != arb_idle);
    assign tgt_pkt = (next_state == arb_ibus) ? ibus_cur : dbus_cur;

    // target fault belongs to the access being issued
    assign ibus_fault = tgt_fault & (next_state == arb_ibus);
    assign dbus_fault = tgt_fault & (next_state == arb_dbus);

    assign ibus_resp  = tgt_resp & (state == arb_ibus);
    assign dbus_resp  = tgt_resp & (state == arb_dbus);
    assign ibus_rdata = tgt_rdata;
    assign dbus_rdata = tgt_rdata;

endmodule

`default_nettype wire

// File: src/tcm_target.sv
`timescale 1ns/1ps
`default_nettype none

module tcm_target (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              req,
    input  fabric_pkg::bus_req_t              pkt,
    output logic                              resp,
    output logic [fabric_pkg::bus_width-1:0]  rdata,
    output logic                              fault
);
    import fabric_pkg::*;

    logic [bus_width-1:0] mem [mem_words];
    logic [word_aw-1:0]   idx;
    logic [bus_bytes-1:0] lane_en;
    logic [bus_width-1:0] wdata_sh;
    logic                 misaligned;

    assign idx = pkt.addr[word_aw+1:2];

    always_comb begin
        case (pkt.acc)
            acc_byte: begin
                lane_en    = bus_bytes'(1) << pkt.addr[1:0];
                misaligned = 1'b0;
            end
            acc_half: begin
                lane_en    = bus_bytes'(3) << {pkt.addr[1], 1'b0};
                misaligned = pkt.addr[0];
            end
            default: begin
                lane_en    = '1;
                misaligned = |pkt.addr[1:0];
            end
        endcase
    end

    // write data comes in the low lanes
    assign wdata_sh = pkt.wdata << {pkt.addr[1:0], 3'b000};

    assign fault = req & misaligned;

    always_ff @(posedge clk) begin
        if (req) begin
            rdata <= mem[idx];
        end
        if (req && pkt.w_rb && !misaligned) begin
            for (int i = 0; i < bus_bytes; i++) begin
                if (lane_en[i]) begin
                    mem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp <= 1'b0;
        end else begin
            resp <= req & ~misaligned;
        end
    end

endmodule

`default_nettype wire

// File: src/rom_target.sv
`timescale 1ns/1ps
`default_nettype none

module rom_target (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              req,
    input  fabric_pkg::bus_req_t              pkt,
    output logic                              resp,
    output logic [fabric_pkg::bus_width-1:0]  rdata,
    output logic                              fault
);
    import fabric_pkg::*;

    logic [bus_width-1:0] mem [mem_words];
    logic [word_aw-1:0]   idx;

    initial begin
        $readmemh(rom_init_file, mem);
    end

    assign idx = pkt.addr[word_aw+1:2];

    // any write is illegal
    assign fault = req & pkt.w_rb;

    // whole word regardless of access size
    always_ff @(posedge clk) begin
        if (req) begin
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp <= 1'b0;
        end else begin
            resp <= req & ~pkt.w_rb;
        end
    end

endmodule

`default_nettype wire

// File: src/fault_capture.sv
`timescale 1ns/1ps
`default_nettype none

module fault_capture (
    input  logic                         clk,
    input  logic                         rstn,
    input  fabric_pkg::fault_src_t       ibus_src,
    input  fabric_pkg::fault_src_t       dbus_src,
    input  fabric_pkg::bus_req_t         ibus_pkt,
    input  fabric_pkg::bus_req_t         dbus_pkt,
    output logic                         fault,
    output fabric_pkg::fault_cause_t     fault_cause,
    output logic [fabric_pkg::xlen-1:0]  fault_addr
);
    import fabric_pkg::*;

    logic ibus_hit;
    logic any_fault;

    assign ibus_hit  = |ibus_src;
    assign any_fault = ibus_hit | (|dbus_src);

    // held until reset and overwritten by a later fault
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fault       <= 1'b0;
            fault_cause <= fault_none;
        end else if (any_fault) begin
            fault       <= 1'b1;
            fault_cause <= ibus_hit ? fault_ibus : fault_dbus;
        end
    end

    // instruction bus takes precedence
    always_ff @(posedge clk) begin
        if (any_fault) begin
            fault_addr <= ibus_hit ? ibus_pkt.addr : dbus_pkt.addr;
        end
    end

endmodule

`default_nettype wire

// File: src/fabric_top.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  fabric_pkg::bus_req_t              ibus_pkt,
    input  fabric_pkg::bus_req_t              dbus_pkt,
    input  logic                              ibus_req,
    input  logic                              dbus_req,
    output logic                              ibus_resp,
    output logic                              dbus_resp,
    output logic [fabric_pkg::bus_width-1:0]  ibus_rdata,
    output logic [fabric_pkg::bus_width-1:0]  dbus_rdata,
    output logic                              fault,
    output fabric_pkg::fault_cause_t          fault_cause,
    output logic [fabric_pkg::xlen-1:0]       fault_addr
);
    import fabric_pkg::*;

    target_sel_t ibus_sel;
    target_sel_t dbus_sel;
    logic        ibus_dec_fault;
    logic        dbus_dec_fault;

    // arbiter to decoder responses
    logic                 rom_ibus_resp;
    logic                 rom_dbus_resp;
    logic                 tcm_ibus_resp;
    logic                 tcm_dbus_resp;
    logic [bus_width-1:0] rom_ibus_rdata;
    logic [bus_width-1:0] rom_dbus_rdata;
    logic [bus_width-1:0] tcm_ibus_rdata;
    logic [bus_width-1:0] tcm_dbus_rdata;
    logic                 rom_ibus_fault;
    logic                 rom_dbus_fault;
    logic                 tcm_ibus_fault;
    logic                 tcm_dbus_fault;

    // arbiter to target
    logic                 rom_req;
    logic                 tcm_req;
    bus_req_t             rom_pkt;
    bus_req_t             tcm_pkt;
    logic                 rom_resp;
    logic                 tcm_resp;
    logic [bus_width-1:0] rom_rdata;
    logic [bus_width-1:0] tcm_rdata;
    logic                 rom_fault;
    logic                 tcm_fault;

    fault_src_t ibus_src;
    fault_src_t dbus_src;

    assign ibus_src = '{decode: ibus_dec_fault, rom: rom_ibus_fault, tcm: tcm_ibus_fault};
    assign dbus_src = '{decode: dbus_dec_fault, rom: rom_dbus_fault, tcm: tcm_dbus_fault};

    addr_decode u_ibus_decode (
        .clk          (clk),
        .rstn         (rstn),
        .req          (ibus_req),
        .pkt          (ibus_pkt),
        .fault        (fault),
        .sel_req      (ibus_sel),
        .rom_resp     (rom_ibus_resp),
        .tcm_resp     (tcm_ibus_resp),
        .rom_rdata    (rom_ibus_rdata),
        .tcm_rdata    (tcm_ibus_rdata),
        .resp         (ibus_resp),
        .rdata        (ibus_rdata),
        .decode_fault (ibus_dec_fault)
    );

    addr_decode u_dbus_decode (
        .clk          (clk),
        .rstn         (rstn),
        .req          (dbus_req),
        .pkt          (dbus_pkt),
        .fault        (fault),
        .sel_req      (dbus_sel),
        .rom_resp     (rom_dbus_resp),
        .tcm_resp     (tcm_dbus_resp),
        .rom_rdata    (rom_dbus_rdata),
        .tcm_rdata    (tcm_dbus_rdata),
        .resp         (dbus_resp),
        .rdata        (dbus_rdata),
        .decode_fault (dbus_dec_fault)
    );

    bus_arbiter u_rom_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .ibus_req   (ibus_sel.rom),
        .dbus_req   (dbus_sel.rom),
        .ibus_pkt   (ibus_pkt),
        .dbus_pkt   (dbus_pkt),
        .ibus_resp  (rom_ibus_resp),
        .dbus_resp  (rom_dbus_resp),
        .ibus_rdata (rom_ibus_rdata),
        .dbus_rdata (rom_dbus_rdata),
        .ibus_fault (rom_ibus_fault),
        .dbus_fault (rom_dbus_fault),
        .tgt_req    (rom_req),
        .tgt_pkt    (rom_pkt),
        .tgt_resp   (rom_resp),
        .tgt_rdata  (rom_rdata),
        .tgt_fault  (rom_fault)
    );

    bus_arbiter u_tcm_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .ibus_req   (ibus_sel.tcm),
        .dbus_req   (dbus_sel.tcm),
        .ibus_pkt   (ibus_pkt),
        .dbus_pkt   (dbus_pkt),
        .ibus_resp  (tcm_ibus_resp),
        .dbus_resp  (tcm_dbus_resp),
        .ibus_rdata (tcm_ibus_rdata),
        .dbus_rdata (tcm_dbus_rdata),
        .ibus_fault (tcm_ibus_fault),
        .dbus_fault (tcm_dbus_fault),
        .tgt_req    (tcm_req),
        .tgt_pkt    (tcm_pkt),
        .tgt_resp   (tcm_resp),
        .tgt_rdata  (tcm_rdata),
        .tgt_fault  (tcm_fault)
    );

    rom_target u_rom (
        .clk   (clk),
        .rstn  (rstn),
        .req   (rom_req),
        .pkt   (rom_pkt),
        .resp  (rom_resp),
        .rdata (rom_rdata),
        .fault (rom_fault)
    );

    tcm_target u_tcm (
        .clk   (clk),
        .rstn  (rstn),
        .req   (tcm_req),
        .pkt   (tcm_pkt),
        .resp  (tcm_resp),
        .rdata (tcm_rdata),
        .fault (tcm_fault)
    );

    fault_capture u_fault (
        .clk         (clk),
        .rstn        (rstn),
        .ibus_src    (ibus_src),
        .dbus_src    (dbus_src),
        .ibus_pkt    (ibus_pkt),
        .dbus_pkt    (dbus_pkt),
        .fault       (fault),
        .fault_cause (fault_cause),
        .fault_addr  (fault_addr)
    );

endmodule

`default_nettype wire

// File: test/fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_tb;
    import fabric_pkg::*;

    localparam int n_tests = 26;
    localparam int max_wait = 4;
    localparam logic [31:0] seed = 32'h31fc9e94;

    typedef struct packed {
        logic         dbus;
        logic         wr;
        bus_acc_t     acc;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        fault_cause_t cause;
        logic         pair;
    } test_entry_t;

    logic                 clk;
    logic                 rstn;
    bus_req_t             ibus_pkt;
    bus_req_t             dbus_pkt;
    logic                 ibus_req;
    logic                 dbus_req;
    logic                 ibus_resp;
    logic                 dbus_resp;
    logic [bus_width-1:0] ibus_rdata;
    logic [bus_width-1:0] dbus_rdata;
    logic                 fault;
    fault_cause_t         fault_cause;
    logic [xlen-1:0]      fault_addr;

    test_entry_t tests [n_tests];
    logic [31:0] rom_model [16];
    logic [31:0] tcm_model [mem_words];
    logic [31:0] rng;
    int          errors;
    int          tests_run;

    fabric_top u_fabric_top (
        .clk         (clk),
        .rstn        (rstn),
        .ibus_pkt    (ibus_pkt),
        .dbus_pkt    (dbus_pkt),
        .ibus_req    (ibus_req),
        .dbus_req    (dbus_req),
        .ibus_resp   (ibus_resp),
        .dbus_resp   (dbus_resp),
        .ibus_rdata  (ibus_rdata),
        .dbus_rdata  (dbus_rdata),
        .fault       (fault),
        .fault_cause (fault_cause),
        .fault_addr  (fault_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (n_tests * 20) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", n_tests * 20);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic in_tcm(input logic [31:0] addr);
        return addr[31:12] == 20'h10000;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (in_tcm(addr)) begin
            return tcm_model[addr[11:2]];
        end
        return rom_model[addr[5:2]];
    endfunction

    function automatic test_entry_t make_entry(input logic dbus, input logic wr,
                                               input bus_acc_t acc, input logic [31:0] addr,
                                               input fault_cause_t cause, input logic pair);
        test_entry_t e;
        e.dbus  = dbus;
        e.wr    = wr;
        e.acc   = acc;
        e.addr  = addr;
        e.wdata = '0;
        e.cause = cause;
        e.pair  = pair;
        return e;
    endfunction

    // byte lanes picked by size and low address bits
    task automatic model_write(input test_entry_t e);
        logic [31:0] w;
        w = tcm_model[e.addr[11:2]];
        case (e.acc)
            acc_byte: w[8*e.addr[1:0] +: 8] = e.wdata[7:0];
            acc_half: w[16*e.addr[1] +: 16] = e.wdata[15:0];
            default:  w = e.wdata;
        endcase
        tcm_model[e.addr[11:2]] = w;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // bus, write, size, address, fault cause, issued with next
    task automatic build_table();
        tests[0]  = make_entry(0, 0, acc_word, 32'h0000_0000, fault_none, 0);
        tests[1]  = make_entry(1, 0, acc_word, 32'h0000_0004, fault_none, 0);
        tests[2]  = make_entry(0, 0, acc_word, 32'h0000_003c, fault_none, 0);
        tests[3]  = make_entry(1, 0, acc_byte, 32'h0000_000b, fault_none, 0);
        tests[4]  = make_entry(1, 1, acc_word, 32'h1000_0000, fault_none, 0);
        tests[5]  = make_entry(1, 1, acc_word, 32'h1000_0004, fault_none, 0);
        tests[6]  = make_entry(1, 1, acc_word, 32'h1000_0008, fault_none, 0);
        tests[7]  = make_entry(1, 1, acc_byte, 32'h1000_0001, fault_none, 0);
        tests[8]  = make_entry(1, 1, acc_byte, 32'h1000_0007, fault_none, 0);
        tests[9]  = make_entry(1, 1, acc_half, 32'h1000_0002, fault_none, 0);
        tests[10] = make_entry(1, 1, acc_half, 32'h1000_0008, fault_none, 0);
        tests[11] = make_entry(1, 0, acc_word, 32'h1000_0000, fault_none, 0);
        tests[12] = make_entry(0, 0, acc_word, 32'h1000_0004, fault_none, 0);
        tests[13] = make_entry(0, 0, acc_word, 32'h1000_0008, fault_none, 0);
        // contention on one target, then two targets in parallel
        tests[14] = make_entry(0, 0, acc_word, 32'h1000_0000, fault_none, 1);
        tests[15] = make_entry(1, 0, acc_word, 32'h1000_0004, fault_none, 0);
        tests[16] = make_entry(1, 0, acc_word, 32'h0000_0010, fault_none, 1);
        tests[17] = make_entry(0, 0, acc_word, 32'h0000_0014, fault_none, 0);
        tests[18] = make_entry(0, 0, acc_word, 32'h0000_0018, fault_none, 1);
        tests[19] = make_entry(1, 0, acc_word, 32'h1000_0008, fault_none, 0);
        tests[20] = make_entry(1, 1, acc_word, 32'h0000_0020, fault_dbus, 0);
        tests[21] = make_entry(0, 0, acc_word, 32'h2000_0040, fault_ibus, 0);
        tests[22] = make_entry(1, 1, acc_half, 32'h1000_0005, fault_dbus, 0);
        tests[23] = make_entry(1, 0, acc_word, 32'h1000_0004, fault_none, 0);
        tests[24] = make_entry(1, 1, acc_byte, 32'h1000_0000, fault_none, 1);
        tests[25] = make_entry(0, 0, acc_word, 32'h1000_0000, fault_none, 0);
        for (int k = 0; k < n_tests; k++) begin
            rng = xorshift(rng);
            tests[k].wdata = rng;
        end
    endtask

    task automatic drive_request(input test_entry_t e);
        bus_req_t p;
        p.addr  = e.addr;
        p.w_rb  = e.wr;
        p.acc   = e.acc;
        p.wdata = e.wdata;
        if (e.dbus) begin
            dbus_pkt <= p;
            dbus_req <= 1'b1;
        end else begin
            ibus_pkt <= p;
            ibus_req <= 1'b1;
        end
    endtask

    task automatic check_quiet_after_reset();
        repeat (3) begin
            @(negedge clk);
            check_val("fault", fault, 1'b0);
            check_val("fault_cause", fault_cause, fault_none);
            check_val("ibus_resp", ibus_resp, 1'b0);
            check_val("dbus_resp", dbus_resp, 1'b0);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rstn     <= 1'b0;
        ibus_req <= 1'b0;
        dbus_req <= 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        check_quiet_after_reset();
    endtask

    task automatic run_access(input int first, input int count);
        test_entry_t e;
        logic        i_open;
        logic        d_open;
        logic        d_rd;
        logic        same_tgt;
        int          i_lat;
        logic [31:0] i_exp;
        logic [31:0] d_exp;
        int          err_before;
        err_before = errors;
        i_open = 1'b0;
        d_open = 1'b0;
        d_rd = 1'b0;
        i_exp = '0;
        d_exp = '0;
        same_tgt = (count == 2) && (in_tcm(tests[first].addr) == in_tcm(tests[first+1].addr));
        i_lat = same_tgt ? 2 : 1;
        // data bus is served first when both collide
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = first; k < first + count; k++) begin
                e = tests[k];
                if (e.dbus == (pass == 0)) begin
                    if (e.dbus) begin
                        d_open = 1'b1;
                        d_rd = !e.wr;
                        d_exp = model_read(e.addr);
                    end else begin
                        i_open = 1'b1;
                        i_exp = model_read(e.addr);
                    end
                    if (e.wr) begin
                        model_write(e);
                    end
                end
            end
        end
        @(posedge clk);
        for (int k = first; k < first + count; k++) begin
            drive_request(tests[k]);
        end
        @(posedge clk);
        ibus_req <= 1'b0;
        dbus_req <= 1'b0;
        for (int cyc = 1; cyc <= max_wait; cyc++) begin
            @(negedge clk);
            if (ibus_resp && !i_open) begin
                $display("test %0d: unexpected response on the instruction bus", first);
                errors++;
            end else if (ibus_resp) begin
                check_val("ibus_resp latency", cyc, i_lat);
                check_val("ibus_rdata", ibus_rdata, i_exp);
                i_open = 1'b0;
            end
            if (dbus_resp && !d_open) begin
                $display("test %0d: unexpected response on the data bus", first);
                errors++;
            end else if (dbus_resp) begin
                check_val("dbus_resp latency", cyc, 1);
                if (d_rd) begin
                    check_val("dbus_rdata", dbus_rdata, d_exp);
                end
                d_open = 1'b0;
            end
            check_val("fault", fault, 1'b0);
        end
        if (i_open) begin
            $display("test %0d: no response on the instruction bus within %0d cycles",
                     first, max_wait);
            errors++;
        end
        if (d_open) begin
            $display("test %0d: no response on the data bus within %0d cycles", first, max_wait);
            errors++;
        end
        for (int k = first; k < first + count; k++) begin
            $display("test %0d: %s %s addr %h %s", k, tests[k].dbus ? "dbus" : "ibus",
                     tests[k].wr ? "write" : "read", tests[k].addr,
                     (errors == err_before) ? "ok" : "mismatch");
        end
        tests_run += count;
    endtask

    task automatic run_fault(input int idx);
        test_entry_t e;
        int          err_before;
        e = tests[idx];
        err_before = errors;
        @(posedge clk);
        drive_request(e);
        @(posedge clk);
        ibus_req <= 1'b0;
        dbus_req <= 1'b0;
        for (int cyc = 1; cyc <= max_wait; cyc++) begin
            @(negedge clk);
            if (ibus_resp || dbus_resp) begin
                $display("test %0d: a response came back for a faulting access", idx);
                errors++;
            end
            if (cyc == 1) begin
                check_val("fault", fault, 1'b1);
                check_val("fault_cause", fault_cause, e.cause);
                check_val("fault_addr", fault_addr, e.addr);
            end
        end
        apply_reset();
        $display("test %0d: fault on addr %h %s", idx, e.addr,
                 (errors == err_before) ? "ok" : "mismatch");
        tests_run++;
    endtask

    initial begin
        int i;
        rstn      = 1'b0;
        ibus_req  = 1'b0;
        dbus_req  = 1'b0;
        ibus_pkt  = '0;
        dbus_pkt  = '0;
        errors    = 0;
        tests_run = 0;
        rng       = seed;
        $readmemh("rom_init.hex", rom_model);
        build_table();
        apply_reset();
        i = 0;
        while (i < n_tests) begin
            if (tests[i].cause != fault_none) begin
                run_fault(i);
                i += 1;
            end else if (tests[i].pair) begin
                run_access(i, 2);
                i += 2;
            end else begin
                run_access(i, 1);
                i += 1;
            end
        end
        $display("summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/fabric_pkg.sv
src/addr_decode.sv
src/bus_arbiter.sv
src/tcm_target.sv
src/rom_target.sv
src/fault_capture.sv
src/fabric_top.sv
test/fabric_tb.sv

// File: rom_init.hex
// one 32-bit word per line, ROM word address 0 upward
// pattern c0de, word index, inverted word index
c0de00ff
c0de01fe
c0de02fd
c0de03fc
c0de04fb
c0de05fa
c0de06f9
c0de07f8
c0de08f7
c0de09f6
c0de0af5
c0de0bf4
c0de0cf3
c0de0df2
c0de0ef1
c0de0ff0
